//--- hdl/video_pkg.sv
package video_pkg;

    typedef logic [8:0] cnt_t;      // pixel / line count and bounds
    typedef logic [1:0] mode_t;
    typedef logic [3:0] reg_addr_t;

    localparam mode_t mode_48k      = 2'd0;
    localparam mode_t mode_128k     = 2'd1;
    localparam mode_t mode_pentagon = 2'd2;

    // register map
    localparam reg_addr_t addr_mode      = 4'd0;
    localparam reg_addr_t addr_ctrl      = 4'd1;   // bit0 raster en, bit1 vint disable
    localparam reg_addr_t addr_raster    = 4'd2;
    localparam reg_addr_t addr_hinit48k  = 4'd3;
    localparam reg_addr_t addr_vinit48k  = 4'd4;
    localparam reg_addr_t addr_hinit128k = 4'd5;
    localparam reg_addr_t addr_vinit128k = 4'd6;
    localparam reg_addr_t addr_hinitpen  = 4'd7;
    localparam reg_addr_t addr_vinitpen  = 4'd8;

    localparam cnt_t hinit_default = 9'd104;   // csync phase after reset

    typedef struct packed {
        cnt_t end_h;
        cnt_t end_v;
        cnt_t hblank_beg;
        cnt_t hblank_end;
        cnt_t hsync_beg;
        cnt_t hsync_end;
        cnt_t vblank_beg;
        cnt_t vblank_end;
        cnt_t vsync_beg;
        cnt_t vsync_end;
        cnt_t vint_line;
        cnt_t hint_beg;
        cnt_t hint_end;
    } timing_t;

    function automatic timing_t timing_for(input mode_t m);
        timing_t t;
        case (m)
            mode_48k: t = '{end_h: 9'd447, end_v: 9'd311,
                            hblank_beg: 9'd320, hblank_end: 9'd415,
                            hsync_beg: 9'd344, hsync_end: 9'd375,
                            vblank_beg: 9'd248, vblank_end: 9'd255,
                            vsync_beg: 9'd248, vsync_end: 9'd251,
                            vint_line: 9'd248, hint_beg: 9'd2, hint_end: 9'd65};
            mode_128k: t = '{end_h: 9'd455, end_v: 9'd310,
                             hblank_beg: 9'd320, hblank_end: 9'd415,
                             hsync_beg: 9'd344, hsync_end: 9'd375,
                             vblank_beg: 9'd248, vblank_end: 9'd255,
                             vsync_beg: 9'd248, vsync_end: 9'd251,
                             vint_line: 9'd248, hint_beg: 9'd4, hint_end: 9'd67};
            // code 3 falls back to pentagon
            mode_pentagon, 2'd3: t = '{end_h: 9'd447, end_v: 9'd319,
                                       hblank_beg: 9'd336, hblank_end: 9'd399,
                                       hsync_beg: 9'd336, hsync_end: 9'd367,
                                       vblank_beg: 9'd240, vblank_end: 9'd271,
                                       vsync_beg: 9'd240, vsync_end: 9'd255,
                                       vint_line: 9'd239, hint_beg: 9'd323,
                                       hint_end: 9'd386};
        endcase
        return t;
    endfunction

endpackage

//--- hdl/video_regs.sv
`timescale 1ns/1ps

module video_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  reg_we,
    input  video_pkg::reg_addr_t  reg_addr,
    input  video_pkg::cnt_t       reg_wdata,
    output video_pkg::mode_t      mode,
    output logic                  raster_enable,
    output logic                  vint_disable,
    output video_pkg::cnt_t       raster_line,
    output video_pkg::cnt_t       hinit48k,
    output video_pkg::cnt_t       vinit48k,
    output video_pkg::cnt_t       hinit128k,
    output video_pkg::cnt_t       vinit128k,
    output video_pkg::cnt_t       hinitpen,
    output video_pkg::cnt_t       vinitpen
);
    import video_pkg::*;

    //////////////////////////////
    // write decode
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode          <= mode_48k;
            raster_enable <= 1'b0;
            vint_disable  <= 1'b0;
            raster_line   <= '0;
            hinit48k      <= hinit_default;
            vinit48k      <= '0;
            hinit128k     <= hinit_default;
            vinit128k     <= '0;
            hinitpen      <= hinit_default;
            vinitpen      <= '0;
        end else if (reg_we) begin
            case (reg_addr)
                addr_mode: mode <= reg_wdata[1:0];
                addr_ctrl: begin
                    raster_enable <= reg_wdata[0];
                    vint_disable  <= reg_wdata[1];
                end
                addr_raster:    raster_line <= reg_wdata;
                addr_hinit48k:  hinit48k    <= reg_wdata;
                addr_vinit48k:  vinit48k    <= reg_wdata;
                addr_hinit128k: hinit128k   <= reg_wdata;
                addr_vinit128k: vinit128k   <= reg_wdata;
                addr_hinitpen:  hinitpen    <= reg_wdata;
                addr_vinitpen:  vinitpen    <= reg_wdata;
                default: ;      // above 8, dropped
            endcase
        end
    end

    // mode only moves on a write to its own address
    a_mode_needs_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        $changed(mode) |-> ($past(reg_we) && $past(reg_addr) == addr_mode)
    );

endmodule

//--- hdl/pal_timing.sv
`timescale 1ns/1ps

module pal_timing (
    input  logic              clk,
    input  logic              arst_n,
    input  video_pkg::mode_t  mode,
    output video_pkg::cnt_t   hc,
    output video_pkg::cnt_t   vc,
    output video_pkg::mode_t  cur_mode,
    output logic              frame_start
);
    import video_pkg::*;

    timing_t tm;        // bounds of the latched mode
    logic    h_end;
    logic    v_end;

    assign tm          = timing_for(cur_mode);
    assign h_end       = (hc == tm.end_h);
    assign v_end       = (vc == tm.end_v);
    assign frame_start = h_end && v_end;   // last pixel of last line

    //////////////////////////////
    // pixel and line counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (h_end) begin
            hc <= '0;
            if (v_end) begin
                vc <= '0;
            end else begin
                vc <= vc + 9'd1;
            end
        end else begin
            hc <= hc + 9'd1;
        end
    end

    // new geometry only from the first pixel of a frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_mode <= mode_48k;
        end else if (frame_start) begin
            cur_mode <= mode;
        end
    end

    //////////////////////////////
    // checks
    a_hc_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        hc <= tm.end_h
    );

endmodule

//--- hdl/csync_gen.sv
`timescale 1ns/1ps

module csync_gen (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              frame_start,
    input  video_pkg::mode_t  mode,       // register mode, picked up at the wrap
    input  video_pkg::mode_t  cur_mode,
    input  video_pkg::cnt_t   hinit48k,
    input  video_pkg::cnt_t   vinit48k,
    input  video_pkg::cnt_t   hinit128k,
    input  video_pkg::cnt_t   vinit128k,
    input  video_pkg::cnt_t   hinitpen,
    input  video_pkg::cnt_t   vinitpen,
    output logic              csync
);
    import video_pkg::*;

    timing_t tm;
    cnt_t    hsh;   // phase-shifted pixel count
    cnt_t    vsh;   // phase-shifted line count

    assign tm = timing_for(cur_mode);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsh <= hinit_default;
            vsh <= '0;
        end else if (frame_start) begin
            case (mode)
                mode_48k: begin
                    hsh <= hinit48k;
                    vsh <= vinit48k;
                end
                mode_128k: begin
                    hsh <= hinit128k;
                    vsh <= vinit128k;
                end
                default: begin
                    hsh <= hinitpen;
                    vsh <= vinitpen;
                end
            endcase
        end else if (hsh == tm.end_h) begin
            hsh <= '0;
            vsh <= (vsh == tm.end_v) ? '0 : vsh + 9'd1;
        end else begin
            hsh <= hsh + 9'd1;
        end
    end

    //////////////////////////////
    // pulse shapes per line
    always_comb begin
        csync = 1'b1;
        if (vsh < 9'd248 || vsh > 9'd255) begin
            if (hsh <= 9'd27)
                csync = 1'b0;   // line sync
        end else if (vsh == 9'd251 || vsh == 9'd252) begin
            if (hsh <= 9'd210 || (hsh >= 9'd224 && hsh <= 9'd433))
                csync = 1'b0;   // broad pulses
        end else if (vsh == 9'd253) begin
            if (hsh <= 9'd210 || (hsh >= 9'd224 && hsh <= 9'd237))
                csync = 1'b0;
        end else begin
            // equalizing lines
            if (hsh <= 9'd13 || (hsh >= 9'd224 && hsh <= 9'd237))
                csync = 1'b0;
        end
    end

endmodule

//--- hdl/int_gen.sv
`timescale 1ns/1ps

module int_gen (
    input  video_pkg::cnt_t   hc,
    input  video_pkg::cnt_t   vc,
    input  video_pkg::mode_t  cur_mode,
    input  logic              raster_enable,
    input  logic              vint_disable,
    input  video_pkg::cnt_t   raster_line,
    output logic              int_n,
    output logic              raster_int_active
);
    import video_pkg::*;

    timing_t tm;
    cnt_t    raster_vc;     // line on which the raster int fires
    logic    vint_n;

    assign tm = timing_for(cur_mode);

    // line 0 means the last line of the previous frame
    assign raster_vc = (raster_line == '0) ? tm.end_v : raster_line - 9'd1;

    always_comb begin
        vint_n = 1'b1;
        if (!vint_disable && vc == tm.vint_line &&
            hc >= tm.hint_beg && hc <= tm.hint_end) begin
            vint_n = 1'b0;
        end

        raster_int_active = raster_enable && (vc == raster_vc) &&
                            (hc >= 9'd256) && (hc <= 9'd319);

        int_n = vint_n & ~raster_int_active;   // wired-and of both sources

        if (raster_int_active) begin
            a_raster_on_int: assert (!int_n);
        end
    end

endmodule

//--- hdl/video_out.sv
`timescale 1ns/1ps

module video_out #(
    parameter int color_width = 3
) (
    input  video_pkg::cnt_t         hc,
    input  video_pkg::cnt_t         vc,
    input  video_pkg::mode_t        cur_mode,
    input  logic [color_width-1:0]  ri,
    input  logic [color_width-1:0]  gi,
    input  logic [color_width-1:0]  bi,
    output logic [color_width-1:0]  r,
    output logic [color_width-1:0]  g,
    output logic [color_width-1:0]  b,
    output logic                    hsync,
    output logic                    vsync
);
    import video_pkg::*;

    timing_t tm;
    logic    blank;

    assign tm = timing_for(cur_mode);

    assign blank = (hc >= tm.hblank_beg && hc <= tm.hblank_end) ||
                   (vc >= tm.vblank_beg && vc <= tm.vblank_end);

    //////////////////////////////
    // rgb gate
    assign r = blank ? '0 : ri;
    assign g = blank ? '0 : gi;
    assign b = blank ? '0 : bi;

    // syncs only ever inside blanking, active low
    assign hsync = !(blank && hc >= tm.hsync_beg && hc <= tm.hsync_end);
    assign vsync = !(blank && vc >= tm.vsync_beg && vc <= tm.vsync_end);

endmodule

//--- hdl/video_subsystem.sv
`timescale 1ns/1ps

module video_subsystem #(
    parameter int color_width = 3
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    reg_we,
    input  video_pkg::reg_addr_t    reg_addr,
    input  video_pkg::cnt_t         reg_wdata,
    input  logic [color_width-1:0]  ri,
    input  logic [color_width-1:0]  gi,
    input  logic [color_width-1:0]  bi,
    output video_pkg::cnt_t         hcnt,
    output video_pkg::cnt_t         vcnt,
    output logic [color_width-1:0]  r,
    output logic [color_width-1:0]  g,
    output logic [color_width-1:0]  b,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    csync,
    output logic                    int_n,
    output logic                    raster_int_active
);
    import video_pkg::*;

    mode_t mode;        // as written
    mode_t cur_mode;    // as latched at frame wrap
    logic  raster_enable;
    logic  vint_disable;
    cnt_t  raster_line;
    cnt_t  hinit48k;
    cnt_t  vinit48k;
    cnt_t  hinit128k;
    cnt_t  vinit128k;
    cnt_t  hinitpen;
    cnt_t  vinitpen;
    cnt_t  hc;
    cnt_t  vc;
    logic  frame_start;

    assign hcnt = hc;
    assign vcnt = vc;

    //////////////////////////////
    // blocks
    video_regs video_regs_i (
        .clk(clk), .arst_n(arst_n),
        .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .mode(mode), .raster_enable(raster_enable), .vint_disable(vint_disable),
        .raster_line(raster_line),
        .hinit48k(hinit48k), .vinit48k(vinit48k),
        .hinit128k(hinit128k), .vinit128k(vinit128k),
        .hinitpen(hinitpen), .vinitpen(vinitpen)
    );

    pal_timing pal_timing_i (
        .clk(clk), .arst_n(arst_n), .mode(mode),
        .hc(hc), .vc(vc), .cur_mode(cur_mode), .frame_start(frame_start)
    );

    csync_gen csync_gen_i (
        .clk(clk), .arst_n(arst_n), .frame_start(frame_start),
        .mode(mode), .cur_mode(cur_mode),
        .hinit48k(hinit48k), .vinit48k(vinit48k),
        .hinit128k(hinit128k), .vinit128k(vinit128k),
        .hinitpen(hinitpen), .vinitpen(vinitpen),
        .csync(csync)
    );

    int_gen int_gen_i (
        .hc(hc), .vc(vc), .cur_mode(cur_mode),
        .raster_enable(raster_enable), .vint_disable(vint_disable),
        .raster_line(raster_line),
        .int_n(int_n), .raster_int_active(raster_int_active)
    );

    video_out #(.color_width(color_width)) video_out_i (
        .hc(hc), .vc(vc), .cur_mode(cur_mode),
        .ri(ri), .gi(gi), .bi(bi),
        .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync)
    );

endmodule

//--- tests/tb_video_subsystem.sv
`timescale 1ns/1ps

module tb_video_subsystem;

    localparam int color_width    = 3;
    localparam int timeout_cycles = 6 * 456 * 320 + 100;   // six longest frames plus reset

    //////////////////////////////
    // timing table, index is the mode code, code 3 runs as pentagon
    localparam logic [8:0] end_h_t[4]  = '{9'd447, 9'd455, 9'd447, 9'd447};
    localparam logic [8:0] end_v_t[4]  = '{9'd311, 9'd310, 9'd319, 9'd319};
    localparam logic [8:0] hbl_b_t[4]  = '{9'd320, 9'd320, 9'd336, 9'd336};
    localparam logic [8:0] hbl_e_t[4]  = '{9'd415, 9'd415, 9'd399, 9'd399};
    localparam logic [8:0] hs_b_t[4]   = '{9'd344, 9'd344, 9'd336, 9'd336};
    localparam logic [8:0] hs_e_t[4]   = '{9'd375, 9'd375, 9'd367, 9'd367};
    localparam logic [8:0] vbl_b_t[4]  = '{9'd248, 9'd248, 9'd240, 9'd240};
    localparam logic [8:0] vbl_e_t[4]  = '{9'd255, 9'd255, 9'd271, 9'd271};
    localparam logic [8:0] vs_b_t[4]   = '{9'd248, 9'd248, 9'd240, 9'd240};
    localparam logic [8:0] vs_e_t[4]   = '{9'd251, 9'd251, 9'd255, 9'd255};
    localparam logic [8:0] vint_t[4]   = '{9'd248, 9'd248, 9'd239, 9'd239};
    localparam logic [8:0] hint_b_t[4] = '{9'd2, 9'd4, 9'd323, 9'd323};
    localparam logic [8:0] hint_e_t[4] = '{9'd65, 9'd67, 9'd386, 9'd386};

    logic                   clk       = 1'b0;
    logic                   arst_n    = 1'b0;
    logic                   reg_we    = 1'b0;
    logic [3:0]             reg_addr  = '0;
    logic [8:0]             reg_wdata = '0;
    logic [color_width-1:0] ri        = '0;
    logic [color_width-1:0] gi        = '0;
    logic [color_width-1:0] bi        = '0;
    logic [8:0]             hcnt;
    logic [8:0]             vcnt;
    logic [color_width-1:0] r;
    logic [color_width-1:0] g;
    logic [color_width-1:0] b;
    logic                   hsync;
    logic                   vsync;
    logic                   csync;
    logic                   int_n;
    logic                   raster_int_active;

    integer seed   = 61;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    // model state
    logic [1:0] m_mode;
    logic [1:0] m_cur;
    logic       m_ren;
    logic       m_vdis;
    logic [8:0] m_rline;
    logic [8:0] m_hinit [3];
    logic [8:0] m_vinit [3];
    logic [8:0] m_hc;
    logic [8:0] m_vc;
    logic [8:0] m_hsh;
    logic [8:0] m_vsh;
    logic       m_fs;

    video_subsystem #(.color_width(color_width)) video_subsystem_i (
        .clk(clk), .arst_n(arst_n),
        .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .ri(ri), .gi(gi), .bi(bi),
        .hcnt(hcnt), .vcnt(vcnt), .r(r), .g(g), .b(b),
        .hsync(hsync), .vsync(vsync), .csync(csync),
        .int_n(int_n), .raster_int_active(raster_int_active)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // reference functions
    function automatic int phase_index(input logic [1:0] m);
        return (m == 2'd0) ? 0 : (m == 2'd1) ? 1 : 2;
    endfunction

    function automatic logic blank_ref(input logic [1:0] m, input logic [8:0] h,
                                       input logic [8:0] v);
        return (h >= hbl_b_t[m] && h <= hbl_e_t[m]) || (v >= vbl_b_t[m] && v <= vbl_e_t[m]);
    endfunction

    function automatic logic raster_ref(input logic [1:0] m, input logic [8:0] h,
                                        input logic [8:0] v);
        logic [8:0] line;
        line = (m_rline == 9'd0) ? end_v_t[m] : m_rline - 9'd1;
        return m_ren && v == line && h >= 9'd256 && h <= 9'd319;
    endfunction

    function automatic logic vint_ref(input logic [1:0] m, input logic [8:0] h,
                                      input logic [8:0] v);
        return !m_vdis && v == vint_t[m] && h >= hint_b_t[m] && h <= hint_e_t[m];
    endfunction

    function automatic logic csync_low(input logic [8:0] h, input logic [8:0] v);
        if (v < 9'd248 || v > 9'd255)
            return h <= 9'd27;
        if (v == 9'd251 || v == 9'd252)
            return h <= 9'd210 || (h >= 9'd224 && h <= 9'd433);   // broad
        if (v == 9'd253)
            return h <= 9'd210 || (h >= 9'd224 && h <= 9'd237);
        return h <= 9'd13 || (h >= 9'd224 && h <= 9'd237);        // equalizing
    endfunction

    assign m_fs = (m_hc == end_h_t[m_cur]) && (m_vc == end_v_t[m_cur]);

    // registers, mode latch and both counter pairs
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_mode  <= 2'd0;
            m_cur   <= 2'd0;
            m_ren   <= 1'b0;
            m_vdis  <= 1'b0;
            m_rline <= 9'd0;
            m_hinit <= '{9'd104, 9'd104, 9'd104};
            m_vinit <= '{9'd0, 9'd0, 9'd0};
            m_hc    <= 9'd0;
            m_vc    <= 9'd0;
            m_hsh   <= 9'd104;
            m_vsh   <= 9'd0;
        end else begin
            if (reg_we) begin
                case (reg_addr)
                    4'd0: m_mode <= reg_wdata[1:0];
                    4'd1: begin
                        m_ren  <= reg_wdata[0];
                        m_vdis <= reg_wdata[1];
                    end
                    4'd2: m_rline    <= reg_wdata;
                    4'd3: m_hinit[0] <= reg_wdata;
                    4'd4: m_vinit[0] <= reg_wdata;
                    4'd5: m_hinit[1] <= reg_wdata;
                    4'd6: m_vinit[1] <= reg_wdata;
                    4'd7: m_hinit[2] <= reg_wdata;
                    4'd8: m_vinit[2] <= reg_wdata;
                    default: ;
                endcase
            end
            if (m_hc == end_h_t[m_cur]) begin
                m_hc <= 9'd0;
                m_vc <= (m_vc == end_v_t[m_cur]) ? 9'd0 : m_vc + 9'd1;
            end else begin
                m_hc <= m_hc + 9'd1;
            end
            if (m_fs) begin
                m_cur <= m_mode;   // written mode from before this edge
                m_hsh <= m_hinit[phase_index(m_mode)];
                m_vsh <= m_vinit[phase_index(m_mode)];
            end else if (m_hsh == end_h_t[m_cur]) begin
                m_hsh <= 9'd0;
                m_vsh <= (m_vsh == end_v_t[m_cur]) ? 9'd0 : m_vsh + 9'd1;
            end else begin
                m_hsh <= m_hsh + 9'd1;
            end
        end
    end

    task automatic check_value(input string name, input logic [8:0] got,
                               input logic [8:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////
    // compare on the falling edge
    always @(negedge clk) begin : compare
        logic bl;
        logic rint;
        bl   = blank_ref(m_cur, m_hc, m_vc);
        rint = raster_ref(m_cur, m_hc, m_vc);
        check_value("hcnt", hcnt, m_hc);
        check_value("vcnt", vcnt, m_vc);
        check_value("r", 9'(r), bl ? 9'd0 : 9'(ri));
        check_value("g", 9'(g), bl ? 9'd0 : 9'(gi));
        check_value("b", 9'(b), bl ? 9'd0 : 9'(bi));
        check_value("hsync", 9'(hsync), 9'(!(bl && m_hc >= hs_b_t[m_cur] &&
                                            m_hc <= hs_e_t[m_cur])));
        check_value("vsync", 9'(vsync), 9'(!(bl && m_vc >= vs_b_t[m_cur] &&
                                            m_vc <= vs_e_t[m_cur])));
        check_value("csync", 9'(csync), 9'(!csync_low(m_hsh, m_vsh)));
        check_value("int_n", 9'(int_n), 9'(!(rint || vint_ref(m_cur, m_hc, m_vc))));
        check_value("raster_int_active", 9'(raster_int_active), 9'(rint));
        if (!arst_n) begin
            assert (int_n && hsync && vsync && !raster_int_active) else begin
                $display("outputs not inactive while reset is held");
                errors++;
            end
        end
    end

    always @(posedge clk) begin : rgb_drive
        logic [31:0] v;
        v = $random(seed);
        ri <= v[2:0];
        gi <= v[5:3];
        bi <= v[8:6];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("checks %0d errors %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [8:0] data);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    task automatic wait_line(input logic [8:0] line);
        do @(negedge clk); while (vcnt != line);
    endtask

    // runs to the next 0,0 and checks the last position of the frame
    task automatic wait_frame(input logic [8:0] eh, input logic [8:0] ev);
        logic [8:0] ph;
        logic [8:0] pv;
        @(negedge clk);
        do begin
            ph = hcnt;
            pv = vcnt;
            @(negedge clk);
        end while (hcnt != 9'd0 || vcnt != 9'd0);
        check_value("hcnt at wrap", ph, eh);
        check_value("vcnt at wrap", pv, ev);
    endtask

    initial begin
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        // 48K, raster on line 99
        write_reg(4'd2, 9'd100);
        write_reg(4'd1, 9'd1);
        write_reg(4'd9, 9'd2);      // no such register
        wait_line(9'd150);
        write_reg(4'd0, 9'd1);
        wait_frame(9'd447, 9'd311);
        // 128K, frame int off, raster on the last line
        write_reg(4'd1, 9'd3);
        write_reg(4'd2, 9'd0);
        write_reg(4'd7, 9'd37);
        write_reg(4'd8, 9'd9);
        wait_line(9'd100);
        write_reg(4'd0, 9'd2);
        wait_frame(9'd455, 9'd310);
        // pentagon with new csync phase, then back to 48K
        write_reg(4'd1, 9'd0);
        write_reg(4'd3, 9'd200);
        write_reg(4'd4, 9'd300);
        wait_line(9'd200);
        write_reg(4'd0, 9'd0);
        wait_frame(9'd447, 9'd319);
        write_reg(4'd2, 9'd249);    // raster line 248 next to frame int
        write_reg(4'd1, 9'd1);
        wait_frame(9'd447, 9'd311);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/video_pkg.sv
hdl/video_regs.sv
hdl/pal_timing.sv
hdl/csync_gen.sv
hdl/int_gen.sv
hdl/video_out.sv
hdl/video_subsystem.sv
tests/tb_video_subsystem.sv

//--- Makefile
TOP := tb_video_subsystem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
